//--- common/bmb_pkg.sv
// ========================================
// Barrier request collector package
//   PIU, kind and order FIFO counts
//   Vector typedefs for request fields
// ========================================
`default_nettype none

package bmb_pkg;

  // Processor interface units in the cluster
  localparam int piu_num = 4;

  // Barrier kinds, one slice each
  localparam int bar_kind_num = 2;

  // Per-slice order FIFO
  localparam int order_fifo_depth = 4;
  localparam int order_ptr_w = 2;

  // One bit per PIU, for valids and grants
  typedef logic [piu_num-1:0] piu_vec_t;

  // PIU index
  typedef logic [1:0] piu_id_t;

  // Barrier kind
  typedef logic [0:0] bar_kind_t;

  // Barrier request word as issued by a PIU
  typedef logic [8:0] bar_word_t;

  // Bus master id, bit 2 unused and tied low
  typedef logic [2:0] bar_mid_t;

endpackage

`default_nettype wire

//--- common/bar_pick_if.sv
// ========================================
// Holding stage to kind slice link
//   Per-PIU valids and request words
//   Per-PIU grants from the slice
// ========================================
`timescale 1ns/1ps
`default_nettype none

interface bar_pick_if;

  // Pending request of this kind, per PIU
  bmb_pkg::piu_vec_t  valid;
  bmb_pkg::bar_word_t word [bmb_pkg::piu_num];

  // One-hot, consumes the pending request at the edge
  bmb_pkg::piu_vec_t  grant;

  modport holder (
    output valid,
    output word,
    input  grant
  );

  modport slice (
    input  valid,
    input  word,
    output grant
  );

endinterface

`default_nettype wire

//--- common/bar_head_if.sv
// ========================================
// Kind slice to bus merge link
//   Order FIFO head and its pop
// ========================================
`timescale 1ns/1ps
`default_nettype none

interface bar_head_if;

  // Oldest accepted request of the kind
  logic               head_vld;
  bmb_pkg::bar_word_t head_word;
  bmb_pkg::bar_mid_t  head_mid;

  // Only while head_vld, drops the head at the edge
  logic               pop;

  modport slice (
    output head_vld,
    output head_word,
    output head_mid,
    input  pop
  );

  modport merge (
    input  head_vld,
    input  head_word,
    input  head_mid,
    output pop
  );

endinterface

`default_nettype wire

//--- source/bar_req_hold.sv
// ========================================
// PIU barrier request holding stage
//   Pending kind and word per PIU
//   Kind decode toward the slices
//   Busy level back to each PIU
// ========================================
`timescale 1ns/1ps
`default_nettype none

module bar_req_hold (
  input  logic               forever_cpuclk,
  input  logic               arst_n,
  input  bmb_pkg::piu_vec_t  piu_req,
  input  bmb_pkg::bar_kind_t piu_kind [bmb_pkg::piu_num],
  input  bmb_pkg::bar_word_t piu_word [bmb_pkg::piu_num],
  output bmb_pkg::piu_vec_t  piu_busy,
  bar_pick_if.holder         pick [bmb_pkg::bar_kind_num]
);

  // Pending request state
  bmb_pkg::piu_vec_t  pend_vld;
  bmb_pkg::bar_kind_t pend_kind [bmb_pkg::piu_num];
  bmb_pkg::bar_word_t pend_word [bmb_pkg::piu_num];

  // Grants gathered per kind, then per PIU
  bmb_pkg::piu_vec_t  kind_grant [bmb_pkg::bar_kind_num];
  bmb_pkg::piu_vec_t  pend_done;

  for (genvar k = 0; k < bmb_pkg::bar_kind_num; k++) begin : g_kind
    assign kind_grant[k] = pick[k].grant;
    for (genvar i = 0; i < bmb_pkg::piu_num; i++) begin : g_piu
      // Valid only toward the slice of the stored kind
      assign pick[k].valid[i] = pend_vld[i] && (pend_kind[i] == bmb_pkg::bar_kind_t'(k));
      assign pick[k].word[i]  = pend_word[i];
    end
  end

  // Grant seen from the slice owning each PIU's request
  for (genvar i = 0; i < bmb_pkg::piu_num; i++) begin : g_done
    assign pend_done[i] = pend_vld[i] && kind_grant[pend_kind[i]][i];
  end

  // Strobe sets, grant clears
  // PIU never strobes while busy
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      pend_vld <= '0;
    end else begin
      pend_vld <= piu_req | (pend_vld & ~pend_done);
    end
  end

  // Kind and word sampled with the strobe
  always_ff @(posedge forever_cpuclk) begin
    for (int i = 0; i < bmb_pkg::piu_num; i++) begin
      if (piu_req[i]) begin
        pend_kind[i] <= piu_kind[i];
        pend_word[i] <= piu_word[i];
      end
    end
  end

  // Busy for as long as a request waits
  assign piu_busy = pend_vld;

endmodule

`default_nettype wire

//--- bar_kind_slice/bar_prio_rr.sv
// ========================================
// Four-way round-robin arbiter
//   One-hot select among valids
//   Pointer moves past the winner
// ========================================
`timescale 1ns/1ps
`default_nettype none

module bar_prio_rr (
  input  logic              forever_cpuclk,
  input  logic              arst_n,
  input  bmb_pkg::piu_vec_t valid,
  input  logic              advance,
  output bmb_pkg::piu_vec_t sel
);

  // Highest priority requester
  bmb_pkg::piu_id_t ptr;

  // Search state
  bmb_pkg::piu_id_t scan_id;
  bmb_pkg::piu_id_t win_id;
  logic             found;

  // First valid at or after the pointer, index wraps
  always_comb begin
    sel     = '0;
    scan_id = ptr;
    win_id  = ptr;
    found   = 1'b0;
    for (int n = 0; n < bmb_pkg::piu_num; n++) begin
      scan_id = bmb_pkg::piu_id_t'(int'(ptr) + n);
      if (!found && valid[scan_id]) begin
        found  = 1'b1;
        win_id = scan_id;
      end
    end
    if (found) begin
      sel[win_id] = 1'b1;
    end
  end

  // Pointer starts at PIU 0
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      ptr <= '0;
    end else if (advance) begin
      ptr <= bmb_pkg::piu_id_t'(win_id + 1'b1);
    end
  end

endmodule

`default_nettype wire

//--- bar_kind_slice/bar_order_fifo.sv
// ========================================
// Order FIFO of granted requests
//   Circular buffer of word and id
//   Read and write pointers, count
// ========================================
`timescale 1ns/1ps
`default_nettype none

module bar_order_fifo (
  input  logic               forever_cpuclk,
  input  logic               arst_n,
  input  logic               push,
  input  bmb_pkg::bar_word_t push_word,
  input  bmb_pkg::piu_id_t   push_id,
  input  logic               pop,
  output logic               head_vld,
  output bmb_pkg::bar_word_t head_word,
  output bmb_pkg::piu_id_t   head_id,
  output logic               full
);

  // Storage
  bmb_pkg::bar_word_t mem_word [bmb_pkg::order_fifo_depth];
  bmb_pkg::piu_id_t   mem_id [bmb_pkg::order_fifo_depth];

  // Pointers and occupancy
  logic [bmb_pkg::order_ptr_w-1:0] wr_ptr;
  logic [bmb_pkg::order_ptr_w-1:0] rd_ptr;
  logic [bmb_pkg::order_ptr_w:0]   count;

  // Qualified moves
  logic push_ok;
  logic pop_ok;

  assign head_vld = (count != '0);
  assign full     = (count == (bmb_pkg::order_ptr_w + 1)'(bmb_pkg::order_fifo_depth));
  assign push_ok  = push && !full;
  assign pop_ok   = pop && head_vld;

  // Head visible the cycle after its write
  assign head_word = mem_word[rd_ptr];
  assign head_id   = mem_id[rd_ptr];

  always_ff @(posedge forever_cpuclk) begin
    if (push_ok) begin
      mem_word[wr_ptr] <= push_word;
      mem_id[wr_ptr]   <= push_id;
    end
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keep the count
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- bar_kind_slice/bar_kind_slice.sv
// ========================================
// One barrier kind slice
//   Round-robin grant among PIUs
//   Grant held off on a full FIFO
//   Order FIFO of word and source id
// ========================================
`timescale 1ns/1ps
`default_nettype none

module bar_kind_slice (
  input  logic       forever_cpuclk,
  input  logic       arst_n,
  bar_pick_if.slice  pick,
  bar_head_if.slice  head
);

  // Arbiter choice before the full check
  bmb_pkg::piu_vec_t  rr_sel;
  bmb_pkg::piu_vec_t  grant;
  logic               fifo_full;

  // FIFO write side
  logic               push;
  bmb_pkg::bar_word_t push_word;
  bmb_pkg::piu_id_t   push_id;

  // Stored source of the head entry
  bmb_pkg::piu_id_t   head_id;

  bar_prio_rr x_prio_rr (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .valid          (pick.valid),
    .advance        (push),
    .sel            (rr_sel)
  );

  // No grant while the FIFO cannot take the word
  assign grant      = rr_sel & {bmb_pkg::piu_num{~fifo_full}};
  assign pick.grant = grant;
  assign push       = |grant;

  // Winner word and index from the one-hot grant
  always_comb begin
    push_word = '0;
    push_id   = '0;
    for (int i = 0; i < bmb_pkg::piu_num; i++) begin
      if (grant[i]) begin
        push_word = pick.word[i];
        push_id   = bmb_pkg::piu_id_t'(i);
      end
    end
  end

  bar_order_fifo x_order_fifo (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .push           (push),
    .push_word      (push_word),
    .push_id        (push_id),
    .pop            (head.pop),
    .head_vld       (head.head_vld),
    .head_word      (head.head_word),
    .head_id        (head_id),
    .full           (fifo_full)
  );

  // Master id is the PIU index, top bit low
  assign head.head_mid = {1'b0, head_id};

endmodule

`default_nettype wire

//--- source/bar_bus_merge.sv
// ========================================
// Barrier bus merge
//   Alternating choice of slice heads
//   Choice held while the bus stalls
//   Pop of the slice on a transfer
// ========================================
`timescale 1ns/1ps
`default_nettype none

module bar_bus_merge (
  input  logic               forever_cpuclk,
  input  logic               arst_n,
  bar_head_if.merge          head [bmb_pkg::bar_kind_num],
  input  logic               bar_grant,
  output logic               bar_req,
  output bmb_pkg::bar_word_t bar_word,
  output bmb_pkg::bar_mid_t  bar_mid,
  output bmb_pkg::bar_kind_t bar_kind
);

  // Slice heads as arrays
  logic [bmb_pkg::bar_kind_num-1:0] kind_vld;
  bmb_pkg::bar_word_t kind_word [bmb_pkg::bar_kind_num];
  bmb_pkg::bar_mid_t  kind_mid [bmb_pkg::bar_kind_num];

  // Round-robin over kinds
  bmb_pkg::bar_kind_t last_kind;
  bmb_pkg::bar_kind_t scan_kind;
  bmb_pkg::bar_kind_t rr_kind;
  logic               rr_found;

  // Stalled request keeps its kind
  logic               lock_vld;
  bmb_pkg::bar_kind_t lock_kind;
  bmb_pkg::bar_kind_t sel_kind;
  logic               accept;

  for (genvar k = 0; k < bmb_pkg::bar_kind_num; k++) begin : g_head
    assign kind_vld[k]  = head[k].head_vld;
    assign kind_word[k] = head[k].head_word;
    assign kind_mid[k]  = head[k].head_mid;
    assign head[k].pop  = accept && (sel_kind == bmb_pkg::bar_kind_t'(k));
  end

  // Start looking one past the last popped kind
  always_comb begin
    scan_kind = last_kind;
    rr_kind   = last_kind;
    rr_found  = 1'b0;
    for (int n = 1; n <= bmb_pkg::bar_kind_num; n++) begin
      scan_kind = bmb_pkg::bar_kind_t'(int'(last_kind) + n);
      if (!rr_found && kind_vld[scan_kind]) begin
        rr_found = 1'b1;
        rr_kind  = scan_kind;
      end
    end
  end

  assign sel_kind = lock_vld ? lock_kind : rr_kind;
  assign bar_req  = |kind_vld;
  assign bar_word = kind_word[sel_kind];
  assign bar_mid  = kind_mid[sel_kind];
  assign bar_kind = sel_kind;
  assign accept   = bar_req && bar_grant;

  // Reset value points kind 0 first
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      last_kind <= bmb_pkg::bar_kind_t'(bmb_pkg::bar_kind_num - 1);
      lock_vld  <= 1'b0;
      lock_kind <= '0;
    end else begin
      if (accept) begin
        last_kind <= sel_kind;
      end
      lock_vld  <= bar_req && !bar_grant;
      lock_kind <= sel_kind;
    end
  end

endmodule

`default_nettype wire

//--- source/bmb_bar_top.sv
// ========================================
// Barrier request collector top level
//   Plain PIU and barrier bus ports
//   Holding stage, kind slices, merge
// ========================================
`timescale 1ns/1ps
`default_nettype none

module bmb_bar_top (
  input  logic               forever_cpuclk,
  input  logic               arst_n,
  // PIU 0
  input  logic               piu0_bar_req,
  input  bmb_pkg::bar_kind_t piu0_bar_kind,
  input  bmb_pkg::bar_word_t piu0_bar_word,
  output logic               piu0_bar_busy,
  // PIU 1
  input  logic               piu1_bar_req,
  input  bmb_pkg::bar_kind_t piu1_bar_kind,
  input  bmb_pkg::bar_word_t piu1_bar_word,
  output logic               piu1_bar_busy,
  // PIU 2
  input  logic               piu2_bar_req,
  input  bmb_pkg::bar_kind_t piu2_bar_kind,
  input  bmb_pkg::bar_word_t piu2_bar_word,
  output logic               piu2_bar_busy,
  // PIU 3
  input  logic               piu3_bar_req,
  input  bmb_pkg::bar_kind_t piu3_bar_kind,
  input  bmb_pkg::bar_word_t piu3_bar_word,
  output logic               piu3_bar_busy,
  // Barrier bus
  output logic               bar_req,
  output bmb_pkg::bar_word_t bar_word,
  output bmb_pkg::bar_mid_t  bar_mid,
  output bmb_pkg::bar_kind_t bar_kind,
  input  logic               bar_grant
);

  // PIU ports packed by index
  bmb_pkg::piu_vec_t  piu_req;
  bmb_pkg::piu_vec_t  piu_busy;
  bmb_pkg::bar_kind_t piu_kind [bmb_pkg::piu_num];
  bmb_pkg::bar_word_t piu_word [bmb_pkg::piu_num];

  assign piu_req     = {piu3_bar_req, piu2_bar_req, piu1_bar_req, piu0_bar_req};
  assign piu_kind[0] = piu0_bar_kind;
  assign piu_kind[1] = piu1_bar_kind;
  assign piu_kind[2] = piu2_bar_kind;
  assign piu_kind[3] = piu3_bar_kind;
  assign piu_word[0] = piu0_bar_word;
  assign piu_word[1] = piu1_bar_word;
  assign piu_word[2] = piu2_bar_word;
  assign piu_word[3] = piu3_bar_word;

  assign piu0_bar_busy = piu_busy[0];
  assign piu1_bar_busy = piu_busy[1];
  assign piu2_bar_busy = piu_busy[2];
  assign piu3_bar_busy = piu_busy[3];

  // One link pair per barrier kind
  bar_pick_if pick_if [bmb_pkg::bar_kind_num] ();
  bar_head_if head_if [bmb_pkg::bar_kind_num] ();

  bar_req_hold x_req_hold (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .piu_req        (piu_req),
    .piu_kind       (piu_kind),
    .piu_word       (piu_word),
    .piu_busy       (piu_busy),
    .pick           (pick_if)
  );

  for (genvar k = 0; k < bmb_pkg::bar_kind_num; k++) begin : g_slice
    bar_kind_slice x_kind_slice (
      .forever_cpuclk (forever_cpuclk),
      .arst_n         (arst_n),
      .pick           (pick_if[k]),
      .head           (head_if[k])
    );
  end

  bar_bus_merge x_bus_merge (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .head           (head_if),
    .bar_grant      (bar_grant),
    .bar_req        (bar_req),
    .bar_word       (bar_word),
    .bar_mid        (bar_mid),
    .bar_kind       (bar_kind)
  );

endmodule

`default_nettype wire

//--- verification/bmb_bar_checker.sv
// ========================================
// Barrier collector checker
//   Cycle model of hold, slices, merge
//   Per-PIU scoreboard of strobes
//   Busy, bus and stall compares
// ========================================
`timescale 1ns/1ps
`default_nettype none

module bmb_bar_checker (
  input  logic               forever_cpuclk,
  input  logic               arst_n,
  input  bmb_pkg::piu_vec_t  piu_req,
  input  bmb_pkg::bar_kind_t piu_kind [bmb_pkg::piu_num],
  input  bmb_pkg::bar_word_t piu_word [bmb_pkg::piu_num],
  input  bmb_pkg::piu_vec_t  piu_busy,
  input  logic               bar_req,
  input  bmb_pkg::bar_word_t bar_word,
  input  bmb_pkg::bar_mid_t  bar_mid,
  input  bmb_pkg::bar_kind_t bar_kind,
  input  logic               bar_grant,
  output int                 err_cnt,
  output int                 xfer_cnt,
  output int                 open_cnt
);

  // Model of pending requests
  bmb_pkg::piu_vec_t  m_pend;
  bmb_pkg::bar_kind_t m_kind [bmb_pkg::piu_num];
  bmb_pkg::bar_word_t m_word [bmb_pkg::piu_num];

  // Per kind: pointer and queue of {id, word}
  bmb_pkg::piu_id_t   m_ptr [bmb_pkg::bar_kind_num];
  logic [10:0]        m_fifo [bmb_pkg::bar_kind_num][$];

  // Bus side
  bmb_pkg::bar_kind_t m_last;
  logic               m_lock;
  bmb_pkg::bar_kind_t m_lock_kind;
  logic               prev_stall;
  logic [13:0]        prev_bus;

  // Strobed {kind, word} per PIU
  logic [9:0]         exp_q [bmb_pkg::piu_num][$];

  // Inputs settle 1 ns after the rising edge, so the falling edge is quiet
  always @(negedge forever_cpuclk) begin : model
    bmb_pkg::piu_vec_t  done;
    bmb_pkg::bar_kind_t sel;
    bmb_pkg::bar_kind_t other;
    bmb_pkg::piu_id_t   idx;
    bmb_pkg::piu_id_t   win;
    bmb_pkg::piu_id_t   pid;
    logic               m_req;
    logic               found;
    logic [10:0]        head;
    logic [9:0]         exp_e;
    int                 sz [bmb_pkg::bar_kind_num];
    if (!arst_n) begin
      m_pend      = '0;
      m_last      = 1'b1;
      m_lock      = 1'b0;
      m_lock_kind = '0;
      prev_stall  = 1'b0;
      prev_bus    = '0;
      err_cnt     = 0;
      xfer_cnt    = 0;
      open_cnt    = 0;
      for (int k = 0; k < bmb_pkg::bar_kind_num; k++) begin
        m_ptr[k] = '0;
        m_fifo[k].delete();
      end
      for (int i = 0; i < bmb_pkg::piu_num; i++) begin
        exp_q[i].delete();
      end
    end else begin
      if (piu_busy !== m_pend) begin
        err_cnt++;
        $display("[ERROR] %0t: busy %b, expected %b", $time, piu_busy, m_pend);
      end
      // Kind after the last popped one wins, a stalled choice holds
      other = ~m_last;
      m_req = (m_fifo[0].size() != 0) || (m_fifo[1].size() != 0);
      if (m_lock) begin
        sel = m_lock_kind;
      end else if (m_fifo[other].size() != 0) begin
        sel = other;
      end else begin
        sel = m_last;
      end
      if (bar_req !== m_req) begin
        err_cnt++;
        $display("[ERROR] %0t: bar_req %b, expected %b", $time, bar_req, m_req);
      end else if (m_req) begin
        head = m_fifo[sel][0];
        if ({bar_kind, bar_mid, bar_word} !== {sel, 1'b0, head}) begin
          err_cnt++;
          $display("[ERROR] %0t: bus kind %0d mid %0d word %h, expected %0d %0d %h",
                   $time, bar_kind, bar_mid, bar_word, sel, head[10:9], head[8:0]);
        end
      end
      if (prev_stall && ({bar_req, bar_kind, bar_mid, bar_word} !== prev_bus)) begin
        err_cnt++;
        $display("[ERROR] %0t: bus outputs moved during a stall", $time);
      end
      prev_stall = bar_req && !bar_grant;
      prev_bus   = {bar_req, bar_kind, bar_mid, bar_word};
      // Scoreboard on every accepted transfer
      if (bar_req && bar_grant) begin
        xfer_cnt++;
        pid = bar_mid[1:0];
        if (bar_mid[2] || exp_q[pid].size() == 0) begin
          err_cnt++;
          $display("[ERROR] %0t: transfer with mid %0d matches no request", $time, bar_mid);
        end else begin
          exp_e = exp_q[pid].pop_front();
          if (exp_e !== {bar_kind, bar_word}) begin
            err_cnt++;
            $display("[ERROR] %0t: PIU %0d sent kind %0d word %h, expected %0d %h",
                     $time, pid, bar_kind, bar_word, exp_e[9], exp_e[8:0]);
          end
        end
      end
      // Full is judged before this edge's pop
      for (int k = 0; k < bmb_pkg::bar_kind_num; k++) begin
        sz[k] = m_fifo[k].size();
      end
      if (m_req && bar_grant) begin
        void'(m_fifo[sel].pop_front());
        m_last = sel;
      end
      m_lock      = m_req && !bar_grant;
      m_lock_kind = sel;
      // One grant per kind, first pending PIU from the pointer
      done = '0;
      for (int k = 0; k < bmb_pkg::bar_kind_num; k++) begin
        found = 1'b0;
        win   = '0;
        for (int n = 0; n < bmb_pkg::piu_num; n++) begin
          idx = bmb_pkg::piu_id_t'(int'(m_ptr[k]) + n);
          if (!found && m_pend[idx] && m_kind[idx] == bmb_pkg::bar_kind_t'(k)) begin
            found = 1'b1;
            win   = idx;
          end
        end
        if (found && sz[k] < bmb_pkg::order_fifo_depth) begin
          m_fifo[k].push_back({win, m_word[win]});
          done[win] = 1'b1;
          m_ptr[k]  = win + 2'd1;
        end
      end
      m_pend &= ~done;
      for (int i = 0; i < bmb_pkg::piu_num; i++) begin
        if (piu_req[i]) begin
          if (m_pend[i]) begin
            err_cnt++;
            $display("PIU %0d strobed a request while still busy", i);
          end
          m_pend[i] = 1'b1;
          m_kind[i] = piu_kind[i];
          m_word[i] = piu_word[i];
          exp_q[i].push_back({piu_kind[i], piu_word[i]});
        end
      end
      open_cnt = 0;
      for (int i = 0; i < bmb_pkg::piu_num; i++) begin
        open_cnt += exp_q[i].size();
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_bmb_bar.sv
// ========================================
// Barrier collector testbench
//   Clock, reset and stimulus table
//   LFSR for random words and grants
//   DUT, checker and cycle watchdog
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tb_bmb_bar;

  localparam int n_rows = 10;
  localparam int row_margin = 40;
  localparam logic [15:0] lfsr_seed = 16'd40;

  // Bus grant modes
  localparam logic [1:0] gnt_always = 2'd0;
  localparam logic [1:0] gnt_never  = 2'd1;
  localparam logic [1:0] gnt_lfsr   = 2'd2;

  // Word of PIU i sits at bits i*9 and up
  typedef struct packed {
    logic [3:0]  mask;
    logic [3:0]  kinds;
    logic [35:0] words;
    logic        rnd;
    logic [1:0]  gmode;
    logic [7:0]  idle;
  } stim_row_t;

  logic               forever_cpuclk;
  logic               arst_n;
  bmb_pkg::piu_vec_t  piu_req;
  bmb_pkg::bar_kind_t piu_kind [bmb_pkg::piu_num];
  bmb_pkg::bar_word_t piu_word [bmb_pkg::piu_num];
  bmb_pkg::piu_vec_t  piu_busy;
  logic               bar_req;
  bmb_pkg::bar_word_t bar_word;
  bmb_pkg::bar_mid_t  bar_mid;
  bmb_pkg::bar_kind_t bar_kind;
  logic               bar_grant;

  stim_row_t   stim [n_rows];
  logic [1:0]  grant_mode;
  logic [15:0] lfsr_state;
  int          err_cnt;
  int          xfer_cnt;
  int          open_cnt;
  int          cycle_cnt = 0;
  int          cycle_limit;

  bmb_bar_top bmb_bar_top_inst (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .piu0_bar_req   (piu_req[0]),
    .piu0_bar_kind  (piu_kind[0]),
    .piu0_bar_word  (piu_word[0]),
    .piu0_bar_busy  (piu_busy[0]),
    .piu1_bar_req   (piu_req[1]),
    .piu1_bar_kind  (piu_kind[1]),
    .piu1_bar_word  (piu_word[1]),
    .piu1_bar_busy  (piu_busy[1]),
    .piu2_bar_req   (piu_req[2]),
    .piu2_bar_kind  (piu_kind[2]),
    .piu2_bar_word  (piu_word[2]),
    .piu2_bar_busy  (piu_busy[2]),
    .piu3_bar_req   (piu_req[3]),
    .piu3_bar_kind  (piu_kind[3]),
    .piu3_bar_word  (piu_word[3]),
    .piu3_bar_busy  (piu_busy[3]),
    .bar_req        (bar_req),
    .bar_word       (bar_word),
    .bar_mid        (bar_mid),
    .bar_kind       (bar_kind),
    .bar_grant      (bar_grant)
  );

  bmb_bar_checker bmb_bar_checker_inst (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .piu_req        (piu_req),
    .piu_kind       (piu_kind),
    .piu_word       (piu_word),
    .piu_busy       (piu_busy),
    .bar_req        (bar_req),
    .bar_word       (bar_word),
    .bar_mid        (bar_mid),
    .bar_kind       (bar_kind),
    .bar_grant      (bar_grant),
    .err_cnt        (err_cnt),
    .xfer_cnt       (xfer_cnt),
    .open_cnt       (open_cnt)
  );

  // 4 ns period
  initial begin
    forever_cpuclk = 1'b0;
    forever #2 forever_cpuclk = ~forever_cpuclk;
  end

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per word bit
  task automatic random_word(output bmb_pkg::bar_word_t w);
    for (int b = 0; b < 9; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[b] = lfsr_state[0];
    end
  endtask

  // Next edge, then strobes drop and grant follows the mode
  task automatic tick;
    @(posedge forever_cpuclk);
    #1;
    piu_req = '0;
    case (grant_mode)
      gnt_never: bar_grant = 1'b0;
      gnt_lfsr: begin
        lfsr_state = lfsr_next(lfsr_state);
        bar_grant  = lfsr_state[0];
      end
      default: bar_grant = 1'b1;
    endcase
  endtask

  // Watchdog
  always @(posedge forever_cpuclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run still busy after %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin : stimulus
    stim_row_t row;
    int        limit;
    arst_n     = 1'b0;
    piu_req    = '0;
    bar_grant  = 1'b0;
    grant_mode = gnt_always;
    lfsr_state = lfsr_seed;
    for (int i = 0; i < bmb_pkg::piu_num; i++) begin
      piu_kind[i] = '0;
      piu_word[i] = '0;
    end
    // Lone kind 1 strobe, then kind 0 bursts from pointer 0
    stim[0] = '{4'b0001, 4'b0001, 36'h011, 1'b0, gnt_always, 8'd6};
    stim[1] = '{4'b1111, 4'b0000, {9'h104, 9'h103, 9'h102, 9'h101}, 1'b0, gnt_always, 8'd10};
    stim[2] = '{4'b1111, 4'b0000, {9'h0a4, 9'h0a3, 9'h0a2, 9'h0a1}, 1'b0, gnt_always, 8'd10};
    // Mixed kinds, bus alternates
    stim[3] = '{4'b1111, 4'b1010, {9'h1f4, 9'h1f3, 9'h1f2, 9'h1f1}, 1'b0, gnt_always, 8'd12};
    // Stalled bus with a full kind 0 FIFO
    // Late kind 1 head must not move the stalled bus
    stim[4] = '{4'b1111, 4'b0000, {9'h044, 9'h043, 9'h042, 9'h041}, 1'b0, gnt_never, 8'd6};
    stim[5] = '{4'b1111, 4'b1000, {9'h054, 9'h053, 9'h052, 9'h051}, 1'b0, gnt_never, 8'd10};
    stim[6] = '{4'b0000, 4'b0000, 36'h0, 1'b0, gnt_always, 8'd16};
    // Random words under random grants
    stim[7] = '{4'b1111, 4'b0110, 36'h0, 1'b1, gnt_lfsr, 8'd16};
    stim[8] = '{4'b1111, 4'b0000, 36'h0, 1'b1, gnt_lfsr, 8'd16};
    stim[9] = '{4'b0000, 4'b0000, 36'h0, 1'b0, gnt_always, 8'd16};
    limit = 0;
    for (int r = 0; r < n_rows; r++) begin
      limit += stim[r].idle + row_margin;
    end
    cycle_limit = limit;
    repeat (10) @(posedge forever_cpuclk);
    #1;
    arst_n = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      row        = stim[r];
      grant_mode = row.gmode;
      // PIUs of this row must be idle first
      while ((piu_busy & row.mask) != '0) begin
        tick();
      end
      tick();
      piu_req = row.mask;
      for (int i = 0; i < bmb_pkg::piu_num; i++) begin
        piu_kind[i] = row.kinds[i];
        if (row.rnd) begin
          random_word(piu_word[i]);
        end else begin
          piu_word[i] = row.words[i*9 +: 9];
        end
      end
      repeat (row.idle) tick();
    end
    // Drain what is left
    while (open_cnt != 0 || bar_req) begin
      tick();
    end
    tick();
    $display("Closing counts: %0d errors, %0d bus transfers, %0d requests not seen on the bus",
             err_cnt, xfer_cnt, open_cnt);
    if (err_cnt == 0 && open_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
common/bmb_pkg.sv
common/bar_pick_if.sv
common/bar_head_if.sv
source/bar_req_hold.sv
bar_kind_slice/bar_prio_rr.sv
bar_kind_slice/bar_order_fifo.sv
bar_kind_slice/bar_kind_slice.sv
source/bar_bus_merge.sv
source/bmb_bar_top.sv
verification/bmb_bar_checker.sv
verification/tb_bmb_bar.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the barrier collector testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
  -f flist.f \
  --top-module tb_bmb_bar \
  -o sim_tb_bmb_bar

./obj_dir/sim_tb_bmb_bar > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
